/* rtl/dsp_pkg.sv */
package dsp_pkg;

    // Frame geometry
    localparam int num_lanes = 4;
    localparam int win_len   = 2 * num_lanes;
    localparam int ffe_taps  = 3;
    localparam int chan_taps = 3;

    // Stage depths of the three history buffers
    localparam int code_depth = 4;
    localparam int bit_depth  = 5;
    localparam int err_depth  = 2;

    localparam int code_width     = 8;
    localparam int weight_width   = 8;
    localparam int ffe_est_width  = 18;
    localparam int chan_tap_width = 8;
    localparam int est_code_width = 11;
    localparam int err_width      = 12;
    localparam int energy_width   = 26;
    localparam int shift_width    = 3;

    typedef logic signed [code_width-1:0]     code_t;
    typedef logic signed [weight_width-1:0]   weight_t;
    typedef logic signed [ffe_est_width-1:0]  ffe_est_t;
    typedef logic signed [chan_tap_width-1:0] chan_tap_t;
    typedef logic signed [est_code_width-1:0] est_code_t;
    typedef logic signed [err_width-1:0]      err_t;
    typedef logic signed [energy_width-1:0]   energy_t;

    // Right-shift amount, applied arithmetically
    typedef logic [shift_width-1:0] shift_t;

    // Detector verdict, code 3 is never produced
    typedef logic [1:0] err_pos_t;

    localparam err_pos_t pos_no_flip   = 2'd0;
    localparam err_pos_t pos_flip_this = 2'd1;
    localparam err_pos_t pos_flip_next = 2'd2;
    localparam err_pos_t pos_unused    = 2'd3;

endpackage : dsp_pkg

/* rtl/data_buffer.sv */
`timescale 1ns/1ps

module data_buffer
    import dsp_pkg::*;
#(
    parameter type elem_t = logic,
    parameter int  depth  = 1
) (
    input  logic  clk,
    input  logic  reset_i,
    input  elem_t in_i     [num_lanes-1:0],
    output elem_t buffer_o [num_lanes-1:0][depth-1:0]
);

    // Stage 0 holds the newest frame
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < num_lanes; l++) begin
                for (int s = 0; s < depth; s++) begin
                    buffer_o[l][s] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < num_lanes; l++) begin
                buffer_o[l][0] <= in_i[l];
                for (int s = 1; s < depth; s++) begin
                    buffer_o[l][s] <= buffer_o[l][s-1];
                end
            end
        end
    end

    a_depth_min: assert property (@(posedge clk) depth >= 1)
        else $error("data_buffer: depth must be at least 1");

endmodule : data_buffer

/* rtl/comb_ffe.sv */
`timescale 1ns/1ps

module comb_ffe
    import dsp_pkg::*;
(
    input  code_t    codes_i   [win_len-1:0],
    input  weight_t  weights_i [ffe_taps-1:0],
    input  shift_t   shift_i,
    output ffe_est_t est_o     [num_lanes-1:0]
);

    ffe_est_t acc [num_lanes-1:0];

    // FIR over the newer half of the window, taps reach back into the older frame
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            acc[l] = '0;
            for (int j = 0; j < ffe_taps; j++) begin
                acc[l] = acc[l]
                       + ffe_est_t'(codes_i[num_lanes+l-j]) * ffe_est_t'(weights_i[j]);
            end
        end
    end

    // Shift only after full-precision accumulation
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            est_o[l] = acc[l] >>> shift_i;
        end
    end

endmodule : comb_ffe

/* rtl/channel_filter.sv */
`timescale 1ns/1ps

module channel_filter
    import dsp_pkg::*;
(
    input  logic      bits_i     [win_len-1:0],
    input  chan_tap_t taps_i     [chan_taps-1:0],
    input  shift_t    shift_i,
    output est_code_t est_code_o [num_lanes-1:0]
);

    est_code_t tap_ext [chan_taps-1:0];
    est_code_t sum     [num_lanes-1:0];

    always_comb begin
        for (int j = 0; j < chan_taps; j++) begin
            tap_ext[j] = est_code_t'(taps_i[j]);
        end
    end

    // Bit 1 contributes +tap, bit 0 contributes -tap
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            sum[l] = '0;
            for (int j = 0; j < chan_taps; j++) begin
                if (bits_i[num_lanes+l-j]) begin
                    sum[l] = sum[l] + tap_ext[j];
                end else begin
                    sum[l] = sum[l] - tap_ext[j];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            est_code_o[l] = sum[l] >>> shift_i;
        end
    end

endmodule : channel_filter

/* rtl/sliding_detector.sv */
`timescale 1ns/1ps

module sliding_detector
    import dsp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  err_t      errors_i  [win_len-1:0],
    input  logic      bits_i    [win_len-1:0],
    input  chan_tap_t taps_i    [chan_taps-1:0],
    input  shift_t    shift_i,
    output err_pos_t  err_pos_o [num_lanes-1:0]
);

    err_t     delta   [1:0];
    energy_t  e_none  [num_lanes-1:0];
    energy_t  e_this  [num_lanes-1:0];
    energy_t  e_next  [num_lanes-1:0];
    err_pos_t verdict [num_lanes-1:0];

    function automatic energy_t sq(input err_t e);
        energy_t ext;
        ext = energy_t'(e);
        return ext * ext;
    endfunction

    // Flipping a 1 lowers the rebuilt code, so the error drops by the delta
    function automatic err_t inject(input err_t e, input logic b, input err_t d);
        return b ? e - d : e + d;
    endfunction

    // Error change caused by flipping one bit, for the two nearest taps
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            delta[j] = (err_t'(taps_i[j]) <<< 1) >>> shift_i;
        end
    end

    always_comb begin
        for (int q = 0; q < num_lanes; q++) begin
            e_none[q] = sq(errors_i[q]) + sq(errors_i[q+1]) + sq(errors_i[q+2]);

            e_this[q] = sq(inject(errors_i[q], bits_i[q], delta[0]))
                      + sq(inject(errors_i[q+1], bits_i[q], delta[1]))
                      + sq(errors_i[q+2]);

            e_next[q] = sq(errors_i[q])
                      + sq(inject(errors_i[q+1], bits_i[q+1], delta[0]))
                      + sq(inject(errors_i[q+2], bits_i[q+1], delta[1]));
        end
    end

    // Strict compares keep ties on the lower verdict
    always_comb begin
        for (int q = 0; q < num_lanes; q++) begin
            verdict[q] = pos_no_flip;
            if (e_this[q] < e_none[q]) begin
                verdict[q] = pos_flip_this;
            end
            if (e_next[q] < e_none[q] && e_next[q] < e_this[q]) begin
                verdict[q] = pos_flip_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int q = 0; q < num_lanes; q++) begin
                err_pos_o[q] <= pos_no_flip;
            end
        end else begin
            for (int q = 0; q < num_lanes; q++) begin
                err_pos_o[q] <= verdict[q];
            end
        end
    end

    for (genvar q = 0; q < num_lanes; q++) begin : g_verdict_chk
        a_no_code3: assert property (
            @(posedge clk) disable iff (reset_i) err_pos_o[q] != pos_unused
        ) else $error("sliding_detector: lane %0d reported verdict 3", q);
    end

endmodule : sliding_detector

/* rtl/datapath_core.sv */
`timescale 1ns/1ps

module datapath_core
    import dsp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  code_t     adc_codes_i   [num_lanes-1:0],

    input  weight_t   ffe_weights_i [ffe_taps-1:0],
    input  shift_t    ffe_shift_i,
    input  ffe_est_t  thresh_i,
    input  chan_tap_t chan_taps_i   [chan_taps-1:0],
    input  shift_t    chan_shift_i,

    output logic      bits_o        [num_lanes-1:0],
    output err_pos_t  err_pos_o     [num_lanes-1:0]
);

    code_t     code_buf   [num_lanes-1:0][code_depth-1:0];
    logic      bit_buf    [num_lanes-1:0][bit_depth-1:0];
    err_t      err_buf    [num_lanes-1:0][err_depth-1:0];

    code_t     ffe_win    [win_len-1:0];
    logic      chan_win   [win_len-1:0];
    err_t      det_err    [win_len-1:0];
    logic      det_bits   [win_len-1:0];

    ffe_est_t  ffe_est    [num_lanes-1:0];
    ffe_est_t  ffe_q      [num_lanes-1:0];
    logic      sliced     [num_lanes-1:0];
    est_code_t est_code   [num_lanes-1:0];
    est_code_t est_q      [num_lanes-1:0];
    err_t      est_err    [num_lanes-1:0];

    // ADC code history
    data_buffer #(
        .elem_t (code_t),
        .depth  (code_depth)
    ) code_buf_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .in_i     (adc_codes_i),
        .buffer_o (code_buf)
    );

    // Lower half of the window is the older frame
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            ffe_win[l]           = code_buf[l][1];
            ffe_win[num_lanes+l] = code_buf[l][0];
        end
    end

    comb_ffe ffe_i (
        .codes_i   (ffe_win),
        .weights_i (ffe_weights_i),
        .shift_i   (ffe_shift_i),
        .est_o     (ffe_est)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < num_lanes; l++) begin
                ffe_q[l] <= '0;
            end
        end else begin
            ffe_q <= ffe_est;
        end
    end

    // Slicer
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            sliced[l] = (ffe_q[l] >= thresh_i);
        end
    end

    data_buffer #(
        .elem_t (logic),
        .depth  (bit_depth)
    ) bit_buf_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .in_i     (sliced),
        .buffer_o (bit_buf)
    );

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            chan_win[l]           = bit_buf[l][1];
            chan_win[num_lanes+l] = bit_buf[l][0];
        end
    end

    channel_filter chan_filt_i (
        .bits_i     (chan_win),
        .taps_i     (chan_taps_i),
        .shift_i    (chan_shift_i),
        .est_code_o (est_code)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < num_lanes; l++) begin
                est_q[l] <= '0;
            end
        end else begin
            est_q <= est_code;
        end
    end

    // Rebuilt code minus the ADC code of the same frame
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            est_err[l] = err_t'(est_q[l]) - err_t'(code_buf[l][code_depth-1]);
        end
    end

    data_buffer #(
        .elem_t (err_t),
        .depth  (err_depth)
    ) err_buf_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .in_i     (est_err),
        .buffer_o (err_buf)
    );

    // Bits two stages deeper line up with the errors
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            det_err[l]            = err_buf[l][1];
            det_err[num_lanes+l]  = err_buf[l][0];
            det_bits[l]           = bit_buf[l][3];
            det_bits[num_lanes+l] = bit_buf[l][2];
        end
    end

    sliding_detector det_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .errors_i  (det_err),
        .bits_i    (det_bits),
        .taps_i    (chan_taps_i),
        .shift_i   (chan_shift_i),
        .err_pos_o (err_pos_o)
    );

    // Same frame as the registered verdicts
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            bits_o[l] = bit_buf[l][bit_depth-1];
        end
    end

    for (genvar l = 0; l < num_lanes; l++) begin : g_reset_chk
        a_reset_zero: assert property (
            @(posedge clk) $fell(reset_i) |=> !bits_o[l] && err_pos_o[l] == pos_no_flip
        ) else $error("datapath_core: lane %0d output not zero after reset", l);
    end

endmodule : datapath_core

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period_ns = 20,
    parameter int reset_cycles   = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(half_period_ns) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule : tb_clock_gen

/* verif/datapath_core_tb.sv */
`timescale 1ns/1ps

module datapath_core_tb
    import dsp_pkg::*;
;

    localparam int reset_cycles = 5;
    localparam int flush_len    = 6;
    localparam int drain_len    = 8;
    localparam int n_plain      = 40;
    localparam int n_eq         = 40;
    localparam int n_det        = 60;
    localparam int n_craft      = 12;
    localparam int n_segments   = 6;
    localparam int test_cycles  = (reset_cycles + 1) + n_segments * (flush_len + drain_len)
                                + n_plain + 3 * n_eq + n_det + n_craft;
    localparam int timeout_cycles = 2 * test_cycles + reset_cycles;

    logic      clk;
    logic      reset_i;
    code_t     adc_codes_i   [num_lanes-1:0];
    weight_t   ffe_weights_i [ffe_taps-1:0];
    shift_t    ffe_shift_i;
    ffe_est_t  thresh_i;
    chan_tap_t chan_taps_i   [chan_taps-1:0];
    shift_t    chan_shift_i;
    logic      bits_o        [num_lanes-1:0];
    err_pos_t  err_pos_o     [num_lanes-1:0];

    int          cyc;
    int          error_count;
    int          check_count;
    int          test_count;
    int          errors_at_start;
    logic [15:0] lfsr;

    // Model history of the previous frame
    int   m_code [num_lanes];
    logic m_bit  [num_lanes];
    int   m_err  [num_lanes];
    logic m_chk;
    int   seen_flip_this;
    int   seen_flip_next;
    int   seen_tie;

    // Expected results due on a given cycle count
    int         due_q      [$];
    logic [3:0] exp_bits_q [$];
    logic [7:0] exp_pos_q  [$];

    tb_clock_gen #(.half_period_ns(20), .reset_cycles(reset_cycles)) clock_i (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    datapath_core DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .adc_codes_i   (adc_codes_i),
        .ffe_weights_i (ffe_weights_i),
        .ffe_shift_i   (ffe_shift_i),
        .thresh_i      (thresh_i),
        .chan_taps_i   (chan_taps_i),
        .chan_shift_i  (chan_shift_i),
        .bits_o        (bits_o),
        .err_pos_o     (err_pos_o)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_bits(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_err_pos(input string name, input err_pos_t exp, input err_pos_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic compare_due_results();
        logic [3:0] eb;
        logic [7:0] ep;
        while (due_q.size() > 0 && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            eb = exp_bits_q.pop_front();
            ep = exp_pos_q.pop_front();
            for (int l = 0; l < num_lanes; l++) begin
                check_bits($sformatf("bits_o[%0d]", l), eb[l], bits_o[l]);
                check_err_pos($sformatf("err_pos_o[%0d]", l), ep[2*l+:2], err_pos_o[l]);
            end
        end
    endtask

    function automatic int energy3(input int a, input int b, input int c);
        return a * a + b * b + c * c;
    endfunction

    // Reference model takes one frame per call and emits the previous frame's result
    task automatic model_push(input logic [31:0] f, input logic chk);
        int   cw [8];
        logic bw [8];
        int   ew [8];
        int   sum;
        int   d0;
        int   d1;
        int   e_none;
        int   e_this;
        int   e_next;
        logic [3:0] eb;
        logic [7:0] ep;
        for (int l = 0; l < num_lanes; l++) begin
            cw[l] = m_code[l];
            cw[num_lanes+l] = int'(code_t'(f[8*l+:8]));
            bw[l] = m_bit[l];
            ew[l] = m_err[l];
        end
        for (int l = 0; l < num_lanes; l++) begin
            sum = 0;
            for (int j = 0; j < ffe_taps; j++) begin
                sum += int'(ffe_weights_i[j]) * cw[num_lanes+l-j];
            end
            sum = sum >>> ffe_shift_i;
            bw[num_lanes+l] = (sum >= int'(thresh_i));
        end
        for (int l = 0; l < num_lanes; l++) begin
            sum = 0;
            for (int j = 0; j < chan_taps; j++) begin
                sum += bw[num_lanes+l-j] ? int'(chan_taps_i[j]) : -int'(chan_taps_i[j]);
            end
            ew[num_lanes+l] = (sum >>> chan_shift_i) - cw[num_lanes+l];
        end
        d0 = (2 * int'(chan_taps_i[0])) >>> chan_shift_i;
        d1 = (2 * int'(chan_taps_i[1])) >>> chan_shift_i;
        for (int q = 0; q < num_lanes; q++) begin
            e_none = energy3(ew[q], ew[q+1], ew[q+2]);
            e_this = energy3(bw[q] ? ew[q] - d0 : ew[q] + d0,
                             bw[q] ? ew[q+1] - d1 : ew[q+1] + d1, ew[q+2]);
            e_next = energy3(ew[q], bw[q+1] ? ew[q+1] - d0 : ew[q+1] + d0,
                             bw[q+1] ? ew[q+2] - d1 : ew[q+2] + d1);
            ep[2*q+:2] = 2'd0;
            if (e_this < e_none) ep[2*q+:2] = 2'd1;
            if (e_next < e_none && e_next < e_this) ep[2*q+:2] = 2'd2;
            if (m_chk) begin
                if (ep[2*q+:2] == 2'd1) seen_flip_this++;
                if (ep[2*q+:2] == 2'd2) seen_flip_next++;
                if (e_this == e_none) seen_tie++;
            end
            eb[q] = bw[q];
        end
        if (m_chk) begin
            due_q.push_back(cyc + 6);
            exp_bits_q.push_back(eb);
            exp_pos_q.push_back(ep);
        end
        for (int l = 0; l < num_lanes; l++) begin
            m_code[l] = cw[num_lanes+l];
            m_bit[l] = bw[num_lanes+l];
            m_err[l] = ew[num_lanes+l];
        end
        m_chk = chk;
    endtask

    task automatic send_frame(input logic [31:0] f, input logic chk);
        @(negedge clk);
        compare_due_results();
        for (int l = 0; l < num_lanes; l++) begin
            adc_codes_i[l] = f[8*l+:8];
        end
        model_push(f, chk);
    endtask

    task automatic send_zeros(input int n);
        for (int i = 0; i < n; i++) begin
            send_frame('0, 1'b0);
        end
    endtask

    task automatic send_random(input int n);
        logic [31:0] f;
        for (int i = 0; i < n; i++) begin
            rand_bits(32, f);
            send_frame(f, 1'b1);
        end
    endtask

    task automatic set_config(input logic [23:0] w, input shift_t fs, input ffe_est_t th,
                              input logic [23:0] t, input shift_t cs);
        for (int j = 0; j < 3; j++) begin
            ffe_weights_i[j] = w[8*j+:8];
            chan_taps_i[j] = t[8*j+:8];
        end
        ffe_shift_i = fs;
        thresh_i = th;
        chan_shift_i = cs;
        send_zeros(flush_len);
    endtask

    task automatic finish_test(input string name);
        send_zeros(drain_len);
        test_count++;
        $display("Test %s finished with %0d errors", name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    task automatic verify_reset_values();
        // Start counting from the first rising clock edge
        @(posedge clk);
        repeat (reset_cycles + 1) begin
            @(negedge clk);
            for (int l = 0; l < num_lanes; l++) begin
                check_bits($sformatf("bits_o[%0d]", l), 1'b0, bits_o[l]);
                check_err_pos($sformatf("err_pos_o[%0d]", l), 2'd0, err_pos_o[l]);
            end
        end
        test_count++;
        $display("Test reset finished with %0d errors", error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    task automatic plain_slicing();
        set_config(24'h000001, 3'd0, '0, 24'h000000, 3'd0);
        send_random(n_plain);
        finish_test("plain slicing");
    endtask

    task automatic equalization_and_threshold();
        logic [31:0] w;
        logic [15:0] saved;
        rand_bits(24, w);
        saved = lfsr;
        set_config(w[23:0], 3'd2, '0, 24'h000000, 3'd0);
        send_random(n_eq);
        finish_test("equalization");
        // Same codes again against two thresholds
        lfsr = saved;
        set_config(w[23:0], 3'd2, 18'sd300, 24'h000000, 3'd0);
        send_random(n_eq);
        send_zeros(drain_len);
        lfsr = saved;
        set_config(w[23:0], 3'd2, -18'sd300, 24'h000000, 3'd0);
        send_random(n_eq);
        finish_test("threshold");
    endtask

    task automatic random_detector_verdicts();
        logic [31:0] w;
        logic [31:0] t;
        rand_bits(24, w);
        rand_bits(24, t);
        set_config(w[23:0], 3'd3, '0, t[23:0], 3'd1);
        send_random(n_det);
        finish_test("detector verdicts");
    endtask

    task automatic crafted_detector_cases();
        logic [31:0] frames [4];
        // Lane 0 in the low byte; 10 sits below the threshold and is mis-sliced
        frames[0] = 32'h40_40_0A_40;
        frames[1] = 32'h40_40_40_40;
        frames[2] = 32'h40_40_40_00;
        frames[3] = 32'h40_0A_40_40;
        seen_flip_this = 0;
        seen_flip_next = 0;
        seen_tie = 0;
        set_config(24'h000001, 3'd0, 18'sd20, 24'h000040, 3'd0);
        for (int i = 0; i < n_craft; i++) begin
            send_frame(frames[i % 4], 1'b1);
        end
        send_zeros(1);
        if (seen_flip_this == 0 || seen_flip_next == 0 || seen_tie == 0) begin
            error_count++;
            $display("Crafted sequences did not cover verdicts 1, 2 and an energy tie");
        end
        finish_test("detector constructed cases");
    endtask

    initial begin
        cyc = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        errors_at_start = 0;
        lfsr = 16'd19931;
        m_chk = 1'b0;
        for (int l = 0; l < num_lanes; l++) begin
            adc_codes_i[l] = '0;
            m_code[l] = 0;
            m_bit[l] = 1'b0;
            m_err[l] = 0;
        end
        for (int j = 0; j < 3; j++) begin
            ffe_weights_i[j] = '0;
            chan_taps_i[j] = '0;
        end
        ffe_shift_i = '0;
        thresh_i = '0;
        chan_shift_i = '0;

        verify_reset_values();
        plain_slicing();
        equalization_and_threshold();
        random_detector_verdicts();
        crafted_detector_cases();

        if (due_q.size() != 0) begin
            error_count++;
            $display("%0d expected frames were never compared", due_q.size());
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : datapath_core_tb

/* sim.f */
rtl/dsp_pkg.sv
rtl/data_buffer.sv
rtl/comb_ffe.sv
rtl/channel_filter.sv
rtl/sliding_detector.sv
rtl/datapath_core.sv
verif/tb_clock_gen.sv
verif/datapath_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the datapath_core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f sim.f \
    --top-module datapath_core_tb \
    -o Vdatapath_core_tb

./obj_dir/Vdatapath_core_tb | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "NO ERRORS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
